// File: Makefile
TOP := muldiv_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	grep -q "^Simulation PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: filelist.f
src/muldiv_isa_pkg.sv
src/muldiv_ctrl_pkg.sv
src/muldiv_op_if.sv
src/muldiv_ctrl.sv
src/muldiv_step_counter.sv
src/muldiv_multiplier.sv
src/muldiv_divider.sv
src/muldiv.sv
sim/muldiv_tb.sv

// File: sim/muldiv_tb.sv
`default_nettype none

module muldiv_tb
    import muldiv_isa_pkg::*, muldiv_ctrl_pkg::*;
;

    localparam int          MUL_LATENCY   = 2;
    localparam int          CLK_PERIOD    = 8;
    localparam int          DRIVE_DELAY   = 1;         // Inputs change just after the edge
    localparam logic [6:0]  OPCODE_OP     = 7'b0110011;
    localparam logic [6:0]  FUNCT7_MULDIV = 7'b0000001;
    localparam string       TEST_FILE     = "sim/muldiv_tests.txt";

    logic            clk_i = 1'b0;
    logic            reset_i;
    logic            muldiv_request_i;
    logic [XLEN-1:0] inst_i;
    logic [XLEN-1:0] rs1_value_i;
    logic [XLEN-1:0] rs2_value_i;
    logic            muldiv_ready_o;
    logic            writeback_valid_o;
    logic [XLEN-1:0] writeback_value_o;

    // One entry per test line
    logic [2:0]      test_funct3 [$];
    logic [XLEN-1:0] test_rs1    [$];
    logic [XLEN-1:0] test_rs2    [$];
    logic [XLEN-1:0] test_result [$];

    int cycle_count = 0;
    int cycle_limit = 0; // Zero until the tests are loaded

    muldiv #(
        .MUL_LATENCY(MUL_LATENCY)
    ) uut (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .muldiv_request_i  (muldiv_request_i),
        .inst_i            (inst_i),
        .rs1_value_i       (rs1_value_i),
        .rs2_value_i       (rs2_value_i),
        .muldiv_ready_o    (muldiv_ready_o),
        .writeback_valid_o (writeback_valid_o),
        .writeback_value_o (writeback_value_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // Run length guard
    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: no result after %0d cycles, the DUT stopped responding",
                     cycle_count);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // R-type OP instruction of the M extension
    function automatic logic [XLEN-1:0] build_inst(input logic [2:0] funct3);
        return {FUNCT7_MULDIV, 5'd2, 5'd1, funct3, 5'd3, OPCODE_OP};
    endfunction

    task automatic wait_cycle();
        @(posedge clk_i);
        #DRIVE_DELAY; // Outputs settled and safe to sample
    endtask

    task automatic load_tests();
        int              fd;
        int              n;
        string           line;
        logic [XLEN-1:0] f3;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the test file %s", TEST_FILE);
            $display("Simulation FAILED");
            $fatal(1, "missing test file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line[0] != "#") begin // Skip comment lines
                    n = $sscanf(line, "%h %h %h %h", f3, a, b, res);
                    if (n == 4 && f3 < 8) begin
                        test_funct3.push_back(f3[2:0]);
                        test_rs1.push_back(a);
                        test_rs2.push_back(b);
                        test_result.push_back(res);
                    end else if (n > 0) begin
                        $display("Malformed line in the test file: %s", line);
                        $display("Simulation FAILED");
                        $fatal(1, "bad test line");
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(input int idx);
        muldiv_op_e op;
        logic       is_div;
        int         cycles;
        int         expect_cycles;
        string      tag;
        op            = muldiv_op_e'(test_funct3[idx]);
        is_div        = (op == DIV) || (op == DIVU) || (op == REM) || (op == REMU);
        expect_cycles = is_div ? DIV_CYCLES + 2 : MUL_LATENCY + 1; // Edges after acceptance
        tag           = $sformatf("test %0d, %s", idx, op.name());
        while (!muldiv_ready_o) begin
            wait_cycle();
        end
        muldiv_request_i = 1'b1;
        inst_i           = build_inst(test_funct3[idx]);
        rs1_value_i      = test_rs1[idx];
        rs2_value_i      = test_rs2[idx];
        wait_cycle(); // Acceptance edge
        muldiv_request_i = 1'b0;
        inst_i           = build_inst(~test_funct3[idx]); // funct3 must already be registered
        rs1_value_i      = ~test_rs1[idx]; // Operands too
        rs2_value_i      = ~test_rs2[idx];
        cycles           = 0;
        while (!writeback_valid_o) begin
            check_value({"muldiv_ready_o while busy, ", tag}, muldiv_ready_o, 1'b0);
            wait_cycle();
            cycles++;
        end
        check_value({"writeback_valid_o latency, ", tag}, cycles, expect_cycles);
        check_value({"muldiv_ready_o during valid, ", tag}, muldiv_ready_o, 1'b0);
        check_value({"writeback_value_o, ", tag}, writeback_value_o, test_result[idx]);
        wait_cycle();
        check_value({"writeback_valid_o after pulse, ", tag}, writeback_valid_o, 1'b0);
        check_value({"muldiv_ready_o after pulse, ", tag}, muldiv_ready_o, 1'b1);
    endtask

    initial begin
        reset_i          = 1'b1;
        muldiv_request_i = 1'b0;
        inst_i           = '0;
        rs1_value_i      = '0;
        rs2_value_i      = '0;
        load_tests();
        if (test_funct3.size() == 0) begin
            $display("The test file %s holds no tests", TEST_FILE);
            $display("Simulation FAILED");
            $fatal(1, "no tests");
        end
        cycle_limit = test_funct3.size() * (DIV_CYCLES + 8) + 50;
        $display("Loaded %0d tests, cycle limit %0d", test_funct3.size(), cycle_limit);
        repeat (3) @(posedge clk_i); // Reset held for three edges
        #DRIVE_DELAY;
        reset_i = 1'b0;
        check_value("muldiv_ready_o after reset", muldiv_ready_o, 1'b1);
        check_value("writeback_valid_o after reset", writeback_valid_o, 1'b0);
        foreach (test_funct3[i]) begin
            run_test(i); // Next request goes out as soon as ready returns
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/muldiv_tests.txt
# funct3 rs1 rs2 expected, all hex
# funct3: 0 MUL 1 MULH 2 MULHSU 3 MULHU 4 DIV 5 DIVU 6 REM 7 REMU
0 00000007 00000006 0000002a
0 ffffffff 00000005 fffffffb
0 80000000 00000002 00000000
0 0000ffff 0000ffff fffe0001
0 00000000 deadbeef 00000000
0 80000000 ffffffff 80000000
1 ffffffff ffffffff 00000000
1 ffffffff 00000001 ffffffff
1 80000000 80000000 40000000
1 80000000 7fffffff c0000000
1 00010000 00010000 00000001
2 ffffffff ffffffff ffffffff
2 80000000 ffffffff 80000000
2 7fffffff ffffffff 7ffffffe
2 00000002 80000000 00000001
3 ffffffff ffffffff fffffffe
3 80000000 80000000 40000000
3 12345678 00000010 00000001
3 00000000 ffffffff 00000000
4 00000014 00000006 00000003
4 ffffffec 00000006 fffffffd
4 00000014 fffffffa fffffffd
4 ffffffec fffffffa 00000003
4 fffffff9 00000002 fffffffd
4 00000007 00000000 ffffffff
4 fffffff9 00000000 ffffffff
4 80000000 ffffffff 80000000
5 00000014 00000006 00000003
5 ffffffec 00000006 2aaaaaa7
5 ffffffff 00000000 ffffffff
5 80000000 ffffffff 00000000
5 00001000 00000010 00000100
6 00000014 00000006 00000002
6 ffffffec 00000006 fffffffe
6 00000014 fffffffa 00000002
6 fffffff9 00000002 ffffffff
6 00000007 00000000 00000007
6 fffffff9 00000000 fffffff9
6 80000000 ffffffff 00000000
7 ffffffec 00000006 00000002
7 0000000a 00000003 00000001
7 00000007 00000000 00000007
7 ffffffff 00000000 ffffffff
7 80000000 ffffffff 80000000

// File: src/muldiv.sv
`default_nettype none

module muldiv
    import muldiv_isa_pkg::*, muldiv_ctrl_pkg::*;
#(
    parameter int MUL_LATENCY = 2
) (
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic            muldiv_request_i,
    input  logic [XLEN-1:0] inst_i,
    input  logic [XLEN-1:0] rs1_value_i,
    input  logic [XLEN-1:0] rs2_value_i,
    output logic            muldiv_ready_o,
    output logic            writeback_valid_o,
    output logic [XLEN-1:0] writeback_value_o
);

    muldiv_op_e        funct3;
    logic              ctrl_cnt_load;
    logic [CNT_W-1:0]  ctrl_cnt_value;
    logic              div_cnt_load;
    logic [CNT_W-1:0]  div_cnt_value;
    logic              cnt_load;
    logic [CNT_W-1:0]  cnt_value;
    logic              cnt_done;
    logic [2*XLEN-1:0] mul_product;
    logic [XLEN-1:0]   div_quotient;
    logic [XLEN-1:0]   div_remainder;
    logic              div_done;

    muldiv_op_if op_if ();

    assign funct3 = muldiv_op_e'(inst_i[14:12]);

    // One counter, two loaders that are never active together
    assign cnt_load  = ctrl_cnt_load | div_cnt_load;
    assign cnt_value = div_cnt_load ? div_cnt_value : ctrl_cnt_value;

    muldiv_ctrl #(
        .MUL_LATENCY(MUL_LATENCY)
    ) u_ctrl (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .muldiv_request_i  (muldiv_request_i),
        .funct3_i          (funct3),
        .rs1_value_i       (rs1_value_i),
        .rs2_value_i       (rs2_value_i),
        .op                (op_if),
        .cnt_load_o        (ctrl_cnt_load),
        .cnt_value_o       (ctrl_cnt_value),
        .cnt_done_i        (cnt_done),
        .mul_product_i     (mul_product),
        .div_quotient_i    (div_quotient),
        .div_remainder_i   (div_remainder),
        .div_done_i        (div_done),
        .muldiv_ready_o    (muldiv_ready_o),
        .writeback_valid_o (writeback_valid_o),
        .writeback_value_o (writeback_value_o)
    );

    muldiv_step_counter u_counter (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .load_i       (cnt_load),
        .load_value_i (cnt_value),
        .done_o       (cnt_done)
    );

    muldiv_multiplier #(
        .MUL_LATENCY(MUL_LATENCY)
    ) u_mul (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .op        (op_if),
        .product_o (mul_product)
    );

    muldiv_divider u_div (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .op          (op_if),
        .cnt_load_o  (div_cnt_load),
        .cnt_value_o (div_cnt_value),
        .cnt_done_i  (cnt_done),
        .quotient_o  (div_quotient),
        .remainder_o (div_remainder),
        .done_o      (div_done)
    );

endmodule

`default_nettype wire

// File: src/muldiv_ctrl.sv
`default_nettype none

module muldiv_ctrl
    import muldiv_isa_pkg::*, muldiv_ctrl_pkg::*;
#(
    parameter int MUL_LATENCY = 2
) (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                muldiv_request_i,
    input  muldiv_op_e          funct3_i,
    input  logic [XLEN-1:0]     rs1_value_i,
    input  logic [XLEN-1:0]     rs2_value_i,
    muldiv_op_if.ctrl           op,
    output logic                cnt_load_o,
    output logic [CNT_W-1:0]    cnt_value_o,
    input  logic                cnt_done_i,
    input  logic [2*XLEN-1:0]   mul_product_i,
    input  logic [XLEN-1:0]     div_quotient_i,
    input  logic [XLEN-1:0]     div_remainder_i,
    input  logic                div_done_i,
    output logic                muldiv_ready_o,
    output logic                writeback_valid_o,
    output logic [XLEN-1:0]     writeback_value_o
);

    muldiv_state_e state_q;
    logic          accept;
    logic          accept_div; // Accepted op goes to the divider
    logic          is_div_q;
    logic          sel_upper_q; // High half or remainder

    assign muldiv_ready_o = (state_q == IDLE);
    assign accept         = muldiv_request_i && muldiv_ready_o;
    assign accept_div     = accept && op_is_div(funct3_i);

    // Shared counter times the multiply wait
    // Divider loads its own count
    assign cnt_load_o  = accept && !op_is_div(funct3_i);
    assign cnt_value_o = CNT_W'(MUL_LATENCY);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q           <= IDLE;
            writeback_valid_o <= 1'b0;
            op.mul_start      <= 1'b0;
            op.div_start      <= 1'b0;
        end else begin
            op.mul_start <= cnt_load_o; // Launch one cycle after acceptance
            op.div_start <= accept_div;
            // Pulse in the cycle spent in RESPOND
            writeback_valid_o <= (state_q == MUL_WAIT && cnt_done_i) ||
                                 (state_q == DIV_RUN && div_done_i);
            case (state_q)
                IDLE:     if (accept) state_q <= accept_div ? DIV_RUN : MUL_WAIT;
                MUL_WAIT: if (cnt_done_i) state_q <= RESPOND;
                DIV_RUN:  if (div_done_i) state_q <= RESPOND;
                RESPOND:  state_q <= IDLE;
                default:  state_q <= IDLE;
            endcase
        end
    end

    // Operand and result-select capture
    always_ff @(posedge clk_i) begin
        if (accept) begin
            op.a_value  <= rs1_value_i;
            op.b_value  <= rs2_value_i;
            op.a_signed <= op_a_signed(funct3_i);
            op.b_signed <= op_b_signed(funct3_i);
            is_div_q    <= op_is_div(funct3_i);
            sel_upper_q <= op_sel_upper(funct3_i);
        end
    end

    always_comb begin
        case ({is_div_q, sel_upper_q})
            2'b00:   writeback_value_o = mul_product_i[XLEN-1:0];      // MUL
            2'b01:   writeback_value_o = mul_product_i[2*XLEN-1:XLEN]; // MULH*
            2'b10:   writeback_value_o = div_quotient_i;
            default: writeback_value_o = div_remainder_i;
        endcase
    end

    // Requester must wait for ready
    a_req_when_ready: assert property (@(posedge clk_i) disable iff (reset_i)
        muldiv_request_i |-> muldiv_ready_o);

    // Valid only in RESPOND and for a single cycle
    a_valid_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
        writeback_valid_o |-> state_q == RESPOND ##1 !writeback_valid_o && state_q == IDLE);

    // Divider loads the shared counter on div_start
    a_single_load: assert property (@(posedge clk_i) disable iff (reset_i)
        !(cnt_load_o && op.div_start));

endmodule

`default_nettype wire

// File: src/muldiv_ctrl_pkg.sv
`default_nettype none

package muldiv_ctrl_pkg;

    import muldiv_isa_pkg::*;

    // Controller FSM
    typedef enum logic [2:0] {
        IDLE     = 3'd0, // Ready for a request
        MUL_WAIT = 3'd1, // Multiplier pipeline in flight
        DIV_RUN  = 3'd2, // Divider iterating
        RESPOND  = 3'd3  // One-cycle writeback
    } muldiv_state_e;

    localparam int DIV_CYCLES = XLEN; // One quotient bit per cycle
    localparam int CNT_W      = 6;    // Must hold DIV_CYCLES

    // Legal multiplier pipeline depths
    localparam int MUL_LATENCY_MIN = 1;
    localparam int MUL_LATENCY_MAX = 4;

endpackage

`default_nettype wire

// File: src/muldiv_divider.sv
`default_nettype none

module muldiv_divider
    import muldiv_isa_pkg::*, muldiv_ctrl_pkg::*;
(
    input  logic             clk_i,
    input  logic             reset_i,
    muldiv_op_if.div         op,
    output logic             cnt_load_o,
    output logic [CNT_W-1:0] cnt_value_o,
    input  logic             cnt_done_i,
    output logic [XLEN-1:0]  quotient_o,
    output logic [XLEN-1:0]  remainder_o,
    output logic             done_o
);

    logic            running_q;
    logic [XLEN-1:0] divisor_q;
    logic [XLEN-1:0] quot_q;   // Dividend shifts out, quotient bits shift in
    logic [XLEN-1:0] rem_q;    // Partial remainder
    logic            quot_neg_q;
    logic            rem_neg_q;
    logic            div_zero_q;

    logic            a_neg;
    logic            b_neg;
    logic [XLEN-1:0] a_abs;
    logic [XLEN-1:0] b_abs;
    logic [XLEN:0]   shifted; // Remainder with next dividend bit
    logic [XLEN:0]   diff;

    assign a_neg = op.a_signed && op.a_value[XLEN-1];
    assign b_neg = op.b_signed && op.b_value[XLEN-1];
    assign a_abs = a_neg ? -op.a_value : op.a_value;
    assign b_abs = b_neg ? -op.b_value : op.b_value; // -2^31 stays 0x80000000

    // Iteration count comes from the shared counter
    assign cnt_load_o  = op.div_start;
    assign cnt_value_o = CNT_W'(DIV_CYCLES);

    assign done_o = running_q && cnt_done_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            running_q <= 1'b0;
        end else if (op.div_start) begin
            running_q <= 1'b1;
        end else if (done_o) begin
            running_q <= 1'b0;
        end
    end

    assign shifted = {rem_q, quot_q[XLEN-1]};
    assign diff    = shifted - {1'b0, divisor_q};

    always_ff @(posedge clk_i) begin
        if (op.div_start) begin
            divisor_q  <= b_abs;
            quot_q     <= a_abs;
            rem_q      <= '0;
            quot_neg_q <= a_neg ^ b_neg;
            rem_neg_q  <= a_neg; // Remainder follows the dividend
            div_zero_q <= (op.b_value == '0);
        end else if (running_q && !cnt_done_i) begin
            // Restoring step, keep the shifted value on a borrow
            if (diff[XLEN]) begin
                rem_q <= shifted[XLEN-1:0];
            end else begin
                rem_q <= diff[XLEN-1:0];
            end
            quot_q <= {quot_q[XLEN-2:0], !diff[XLEN]};
        end
    end

    // Sign fix-up on the held result
    // With a zero divisor every step subtracts nothing, so rem_q ends as |dividend|
    assign quotient_o  = div_zero_q ? '1 : (quot_neg_q ? -quot_q : quot_q);
    assign remainder_o = rem_neg_q ? -rem_q : rem_q;

    // Result after DIV_CYCLES steps plus the capture cycle
    a_done_time: assert property (@(posedge clk_i) disable iff (reset_i)
        op.div_start |-> ##(DIV_CYCLES+1) done_o);

endmodule

`default_nettype wire

// File: src/muldiv_isa_pkg.sv
`default_nettype none

package muldiv_isa_pkg;

    localparam int XLEN = 32; // RV32 data width

    // funct3 field of the M-extension OP instructions
    typedef enum logic [2:0] {
        MUL    = 3'b000, // Low product
        MULH   = 3'b001, // High, signed x signed
        MULHSU = 3'b010, // High, signed x unsigned
        MULHU  = 3'b011, // High, unsigned x unsigned
        DIV    = 3'b100,
        DIVU   = 3'b101,
        REM    = 3'b110,
        REMU   = 3'b111
    } muldiv_op_e;

    // Divide group has funct3[2] set
    function automatic logic op_is_div(input muldiv_op_e op);
        return op[2];
    endfunction

    function automatic logic op_a_signed(input muldiv_op_e op);
        case (op)
            MULHU, DIVU, REMU: return 1'b0;
            default:           return 1'b1; // MUL, MULH, MULHSU, DIV, REM
        endcase
    endfunction

    function automatic logic op_b_signed(input muldiv_op_e op);
        case (op)
            MUL, MULH, DIV, REM: return 1'b1; // MUL sign is irrelevant for low half
            default:             return 1'b0;
        endcase
    endfunction

    // High product half for MULH*, remainder for REM*
    function automatic logic op_sel_upper(input muldiv_op_e op);
        return op[2] ? op[1] : (op[1:0] != 2'b00);
    endfunction

endpackage

`default_nettype wire

// File: src/muldiv_multiplier.sv
`default_nettype none

module muldiv_multiplier
    import muldiv_isa_pkg::*, muldiv_ctrl_pkg::*;
#(
    parameter int MUL_LATENCY = 2
) (
    input  logic                clk_i,
    input  logic                reset_i,
    muldiv_op_if.mul            op,
    output logic [2*XLEN-1:0]   product_o
);

    logic signed [XLEN:0]     a_ext; // Sign or zero extended to 33 bits
    logic signed [XLEN:0]     b_ext;
    logic signed [2*XLEN-1:0] prod_comb;

    logic [2*XLEN-1:0] prod_q [MUL_LATENCY]; // Stage registers
    logic              vld_q  [MUL_LATENCY]; // Stage valid bits

    if (MUL_LATENCY < MUL_LATENCY_MIN || MUL_LATENCY > MUL_LATENCY_MAX) begin : g_bad_latency
        $error("MUL_LATENCY out of range");
    end

    assign a_ext = {op.a_signed & op.a_value[XLEN-1], op.a_value};
    assign b_ext = {op.b_signed & op.b_value[XLEN-1], op.b_value};

    // Low 64 bits of the 33x33 signed product cover all four variants
    assign prod_comb = a_ext * b_ext;

    // First stage captures on the launch pulse
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            vld_q[0] <= 1'b0;
        end else begin
            vld_q[0] <= op.mul_start;
        end
        if (op.mul_start) begin
            prod_q[0] <= prod_comb;
        end
    end

    // Later stages move only with a valid product and the last one holds
    for (genvar i = 1; i < MUL_LATENCY; i++) begin : g_stage
        always_ff @(posedge clk_i) begin
            if (reset_i) begin
                vld_q[i] <= 1'b0;
            end else begin
                vld_q[i] <= vld_q[i-1];
            end
            if (vld_q[i-1]) begin
                prod_q[i] <= prod_q[i-1];
            end
        end
    end

    assign product_o = prod_q[MUL_LATENCY-1];

    // Launched product leaves the last stage exactly MUL_LATENCY cycles later
    a_latency: assert property (@(posedge clk_i) disable iff (reset_i)
        op.mul_start |-> ##MUL_LATENCY
            vld_q[MUL_LATENCY-1] && product_o == $past(prod_comb, MUL_LATENCY));

endmodule

`default_nettype wire

// File: src/muldiv_op_if.sv
`default_nettype none

// Prepared operation, controller to both datapaths
interface muldiv_op_if
    import muldiv_isa_pkg::*;
();

    logic [XLEN-1:0] a_value;  // rs1 as registered at acceptance
    logic [XLEN-1:0] b_value;  // rs2
    logic            a_signed; // Treat a_value as two's complement
    logic            b_signed;
    logic            mul_start; // One-cycle launch pulses
    logic            div_start;

    modport ctrl (
        output a_value, b_value, a_signed, b_signed, mul_start, div_start
    );

    modport mul (
        input a_value, b_value, a_signed, b_signed, mul_start
    );

    modport div (
        input a_value, b_value, a_signed, b_signed, div_start
    );

endinterface

`default_nettype wire

// File: src/muldiv_step_counter.sv
`default_nettype none

module muldiv_step_counter
    import muldiv_ctrl_pkg::*;
(
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             load_i,
    input  logic [CNT_W-1:0] load_value_i,
    output logic             done_o
);

    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count_q <= '0;
        end else if (load_i) begin
            count_q <= load_value_i;
        end else if (count_q != '0) begin
            count_q <= count_q - 1'b1; // Saturate at zero
        end
    end

    assign done_o = (count_q == '0);

    // A running count is never restarted
    a_load_idle: assert property (@(posedge clk_i) disable iff (reset_i)
        load_i |-> done_o);

endmodule

`default_nettype wire
